// ==== Bender.yml ====
package:
  name: core_balancer

sources:
  - files:
      - hw/axil_pkg.sv
      - hw/bal_regs_pkg.sv
      - hw/bal_op_if.sv
      - hw/axil_decode.sv
      - hw/max_finder_tree.sv
      - hw/slot_table.sv
      - hw/axil_result.sv
      - hw/core_balancer.sv
  - target: test
    files:
      - tests/core_balancer_assertions.sv
      - tests/tb_core_balancer.sv

// ==== flist.f ====
hw/axil_pkg.sv
hw/bal_regs_pkg.sv
hw/bal_op_if.sv
hw/axil_decode.sv
hw/max_finder_tree.sv
hw/slot_table.sv
hw/axil_result.sv
hw/core_balancer.sv
tests/core_balancer_assertions.sv
tests/tb_core_balancer.sv

// ==== hw/axil_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

// Accepts one AXI4-Lite transaction at a time and turns it into an operation.
module axil_decode #(
  parameter int PORT_COUNT = 8
) (
  input  logic            clk,
  input  logic            reset,

  input  axil_pkg::addr_t awaddr,
  input  logic            awvalid,
  output logic            awready,

  input  axil_pkg::data_t wdata,
  input  logic            wvalid,
  output logic            wready,

  input  axil_pkg::addr_t araddr,
  input  logic            arvalid,
  output logic            arready,

  input  logic            busy,   // A response is still waiting to be taken.
  bal_op_if.decode        op
);

  logic write_go; // Address and data of a write are taken in this cycle.
  logic read_go;  // A read address is taken in this cycle.

  // Maps a byte address and a direction onto an operation code.
  function automatic bal_regs_pkg::op_t decode_op(input axil_pkg::addr_t a,
                                                  input logic wr);
    int                slot_end;
    bal_regs_pkg::op_t code;
    slot_end = int'(bal_regs_pkg::REG_SLOTS_BASE) + 4 * PORT_COUNT; // First byte past the slots.
    if (a[1:0] != 2'b00) begin
      code = bal_regs_pkg::OP_BAD; // Only whole aligned words are mapped.
    end else if (a == bal_regs_pkg::REG_ENABLE) begin
      code = wr ? bal_regs_pkg::OP_SET_ENABLE : bal_regs_pkg::OP_READ;
    end else if (a == bal_regs_pkg::REG_SELECT) begin
      code = wr ? bal_regs_pkg::OP_BAD : bal_regs_pkg::OP_READ; // SELECT cannot be written.
    end else if (a == bal_regs_pkg::REG_ALLOC) begin
      code = wr ? bal_regs_pkg::OP_ALLOC : bal_regs_pkg::OP_BAD;
    end else if (a == bal_regs_pkg::REG_RELEASE) begin
      code = wr ? bal_regs_pkg::OP_RELEASE : bal_regs_pkg::OP_BAD;
    end else if (a >= bal_regs_pkg::REG_SLOTS_BASE && int'(a) < slot_end) begin
      code = wr ? bal_regs_pkg::OP_SET_SLOTS : bal_regs_pkg::OP_READ;
    end else begin
      code = bal_regs_pkg::OP_BAD; // Gaps in the map and slots past PORT_COUNT.
    end
    return code;
  endfunction

  // Nothing is accepted while an operation is in flight or a response is held.
  assign write_go = awvalid && wvalid && !busy && !op.op_valid;
  assign read_go  = arvalid && !(awvalid && wvalid) && !busy && !op.op_valid; // Writes win.

  assign awready = write_go; // AW and W are always taken together.
  assign wready  = write_go;
  assign arready = read_go;

  // The operation is presented for exactly one cycle after the handshake.
  always_ff @(posedge clk) begin
    if (reset) begin
      op.op_valid <= 1'b0;
    end else begin
      op.op_valid <= write_go || read_go;
    end
  end

  // Transaction fields, captured only at a handshake.
  always_ff @(posedge clk) begin
    if (write_go) begin
      op.op       <= decode_op(awaddr, 1'b1);
      op.is_write <= 1'b1;
      op.addr     <= awaddr;
      op.wdata    <= wdata;
    end else if (read_go) begin
      op.op       <= decode_op(araddr, 1'b0);
      op.is_write <= 1'b0;
      op.addr     <= araddr; // Write data is left as it was.
    end
  end

endmodule

`default_nettype wire

// ==== hw/axil_pkg.sv ====
`default_nettype none

// Types and response codes shared by every block that touches the AXI4-Lite bus.
package axil_pkg;

  localparam int ADDR_WIDTH = 8;  // The whole register map fits in 256 bytes.
  localparam int DATA_WIDTH = 32; // Registers are always accessed as full words.

  // Byte address as seen on AWADDR and ARADDR.
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // One data beat on WDATA or RDATA.
  typedef logic [DATA_WIDTH-1:0] data_t;

  // Response field on BRESP and RRESP.
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'b00; // Access completed normally.
  localparam resp_t RESP_SLVERR = 2'b10; // Access reached the slave but was refused.

endpackage

`default_nettype wire

// ==== hw/axil_result.sv ====
`timescale 1ns/10ps
`default_nettype none

// Holds the B or R response of the current transaction until the master takes it.
module axil_result (
  input  logic            clk,
  input  logic            reset,
  bal_op_if.result        op,

  output axil_pkg::resp_t bresp,
  output logic            bvalid,
  input  logic            bready,

  output axil_pkg::data_t rdata,
  output axil_pkg::resp_t rresp,
  output logic            rvalid,
  input  logic            rready,

  output logic            busy    // Stops the decoder from taking anything new.
);

  // Only one transaction is ever in flight, so a new op never meets a pending response.
  always_ff @(posedge clk) begin
    if (reset) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
      if (op.op_valid) begin
        bvalid <= bvalid || op.is_write;
        rvalid <= rvalid || !op.is_write;
      end
    end
  end

  // Response contents follow the table's verdict in the op_valid cycle.
  always_ff @(posedge clk) begin
    if (op.op_valid) begin
      if (op.is_write) begin
        bresp <= op.err ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
      end else begin
        rresp <= op.err ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
        rdata <= op.rdata; // Already zero on a refused read.
      end
    end
  end

  assign busy = bvalid || rvalid;

endmodule

`default_nettype wire

// ==== hw/bal_op_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// Carries one decoded operation to the slot table and its outcome to the response stage.
interface bal_op_if #(
  parameter int PORT_COUNT = 8,
  parameter int SLOT_WIDTH = 8
) ();

  logic               op_valid; // One-cycle pulse per accepted transaction.
  bal_regs_pkg::op_t  op;       // What the transaction asks for.
  logic               is_write; // Chooses between the B and the R channel.
  axil_pkg::addr_t    addr;     // Byte address, kept for slot indexing and read muxing.
  axil_pkg::data_t    wdata;    // Write data, unused on reads.
  axil_pkg::data_t    rdata;    // Read data from the table, valid with op_valid.
  logic               err;      // The operation was refused and changed nothing.

  // The map has sixteen slot registers and the SELECT count field is one byte wide.
  if (PORT_COUNT < 2 || PORT_COUNT > 16) begin : g_port_count_check
    $error("PORT_COUNT must lie between 2 and 16.");
  end
  if (SLOT_WIDTH < 1 || SLOT_WIDTH > 8) begin : g_slot_width_check
    $error("SLOT_WIDTH must lie between 1 and 8.");
  end

  modport decode (output op_valid, op, is_write, addr, wdata);
  modport tbl (input op_valid, op, addr, wdata, output rdata, err);
  modport result (input op_valid, is_write, rdata, err);

endinterface

`default_nettype wire

// ==== hw/bal_regs_pkg.sv ====
`default_nettype none

// Register map of the balancer and the operation codes that the decoder hands to the
// slot table.
package bal_regs_pkg;

  localparam axil_pkg::addr_t REG_ENABLE     = 8'h00; // Enable mask, read and write.
  localparam axil_pkg::addr_t REG_SELECT     = 8'h04; // Current selection, read only.
  localparam axil_pkg::addr_t REG_ALLOC      = 8'h08; // Take one slot from the selection.
  localparam axil_pkg::addr_t REG_RELEASE    = 8'h0C; // Give one slot back to a core.
  localparam axil_pkg::addr_t REG_SLOTS_BASE = 8'h20; // Core i lives at base plus 4*i.

  // Layout of the SELECT word.
  localparam int SEL_VALID_BIT = 31; // Set when some enabled core has a free slot.
  localparam int SEL_COUNT_LSB = 8;  // Free slots of the selected core, bits 15 to 8.
  localparam int SEL_INDEX_LSB = 0;  // Index of the selected core, bits 7 to 0.

  // One decoded bus transaction.
  // Reads of any mapped register share one code; the table looks at the address itself.
  typedef enum logic [2:0] {
    OP_SET_ENABLE = 3'd0, // Write of the enable mask.
    OP_SET_SLOTS  = 3'd1, // Write of one core's slot count.
    OP_ALLOC      = 3'd2, // Take a slot from the selected core.
    OP_RELEASE    = 3'd3, // Return a slot to the core named in the data.
    OP_READ       = 3'd4, // Any mapped read.
    OP_BAD        = 3'd5  // Unmapped, misaligned or wrong direction.
  } op_t;

endpackage

`default_nettype wire

// ==== hw/core_balancer.sv ====
`timescale 1ns/10ps
`default_nettype none

// Core load balancer with an AXI4-Lite register interface.
module core_balancer #(
  parameter int PORT_COUNT = 8, // Number of cores, 2 to 16.
  parameter int SLOT_WIDTH = 8  // Width of a free slot count, 1 to 8.
) (
  input  logic            clk,
  input  logic            reset,

  input  axil_pkg::addr_t awaddr,
  input  logic            awvalid,
  output logic            awready,

  input  axil_pkg::data_t wdata,
  input  logic            wvalid,
  output logic            wready,

  output axil_pkg::resp_t bresp,
  output logic            bvalid,
  input  logic            bready,

  input  axil_pkg::addr_t araddr,
  input  logic            arvalid,
  output logic            arready,

  output axil_pkg::data_t rdata,
  output axil_pkg::resp_t rresp,
  output logic            rvalid,
  input  logic            rready
);

  logic busy; // A response is waiting on the B or R channel.

  bal_op_if #(
    .PORT_COUNT (PORT_COUNT),
    .SLOT_WIDTH (SLOT_WIDTH)
  ) op_bus ();

  axil_decode #(
    .PORT_COUNT (PORT_COUNT)
  ) u_decode (
    .clk     (clk),
    .reset   (reset),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .busy    (busy),
    .op      (op_bus.decode)
  );

  slot_table #(
    .PORT_COUNT (PORT_COUNT),
    .SLOT_WIDTH (SLOT_WIDTH)
  ) u_table (
    .clk   (clk),
    .reset (reset),
    .op    (op_bus.tbl)
  );

  axil_result u_result (
    .clk    (clk),
    .reset  (reset),
    .op     (op_bus.result),
    .bresp  (bresp),
    .bvalid (bvalid),
    .bready (bready),
    .rdata  (rdata),
    .rresp  (rresp),
    .rvalid (rvalid),
    .rready (rready),
    .busy   (busy)
  );

endmodule

`default_nettype wire

// ==== hw/max_finder_tree.sv ====
`timescale 1ns/10ps
`default_nettype none

// Finds the largest valid value and its index in one combinational pass.
module max_finder_tree #(
  parameter int PORT_COUNT = 8,
  parameter int SLOT_WIDTH = 8
) (
  input  logic [PORT_COUNT*SLOT_WIDTH-1:0] values,
  input  logic [PORT_COUNT-1:0]            valids,
  output logic [SLOT_WIDTH-1:0]            max_val,
  output logic [$clog2(PORT_COUNT)-1:0]    max_ptr,
  output logic                             max_valid
);

  localparam int IDX_W     = $clog2(PORT_COUNT);
  localparam int PAD_COUNT = 1 << IDX_W; // Leaves of a full binary tree.

  typedef logic [SLOT_WIDTH-1:0] slot_t;
  typedef logic [IDX_W-1:0]      idx_t;

  // Tree nodes in heap order.
  // Node 1 is the root, node n has children 2n and 2n+1, and leaves start at PAD_COUNT.
  slot_t node_val [1:2*PAD_COUNT-1];
  idx_t  node_ptr [1:2*PAD_COUNT-1];

  genvar leaf, lvl, pos;

  generate
    for (leaf = 0; leaf < PAD_COUNT; leaf++) begin : g_leaf
      if (leaf < PORT_COUNT) begin : g_port
        // An invalid input behaves like a core with nothing to offer.
        assign node_val[PAD_COUNT+leaf] =
          valids[leaf] ? values[leaf*SLOT_WIDTH +: SLOT_WIDTH] : slot_t'(0);
      end else begin : g_pad
        assign node_val[PAD_COUNT+leaf] = slot_t'(0); // Padding never beats a real port.
      end
      assign node_ptr[PAD_COUNT+leaf] = idx_t'(leaf);
    end

    // Level 0 is the root, level IDX_W-1 sits just above the leaves.
    for (lvl = 0; lvl < IDX_W; lvl++) begin : g_level
      for (pos = 0; pos < (1 << lvl); pos++) begin : g_node
        localparam int N = (1 << lvl) + pos;
        logic take_hi; // The higher-index child wins only when strictly larger.
        assign take_hi     = node_val[2*N+1] > node_val[2*N];
        assign node_val[N] = take_hi ? node_val[2*N+1] : node_val[2*N];
        assign node_ptr[N] = take_hi ? node_ptr[2*N+1] : node_ptr[2*N];
      end
    end
  endgenerate

  assign max_val   = node_val[1];
  assign max_ptr   = node_ptr[1];
  assign max_valid = node_val[1] != slot_t'(0); // Nonzero root means some masked input is nonzero.

endmodule

`default_nettype wire

// ==== hw/slot_table.sv ====
`timescale 1ns/10ps
`default_nettype none

// Keeps the free slot counts and the enable mask and applies decoded operations to them.
module slot_table #(
  parameter int PORT_COUNT = 8,
  parameter int SLOT_WIDTH = 8
) (
  input  logic clk,
  input  logic reset,
  bal_op_if.tbl op
);

  localparam int IDX_W = $clog2(PORT_COUNT);

  typedef logic [SLOT_WIDTH-1:0] slot_t;
  typedef logic [IDX_W-1:0]      idx_t;

  slot_t                          slots [PORT_COUNT]; // Free slots per core.
  logic [PORT_COUNT-1:0]          enable;             // Cores that may be selected.
  logic [PORT_COUNT*SLOT_WIDTH-1:0] slot_flat;        // Counts packed for the finder.

  slot_t           sel_val;     // Free slots of the selected core.
  idx_t            sel_ptr;     // Index of the selected core.
  logic            sel_valid;   // Some enabled core has at least one free slot.
  axil_pkg::data_t sel_word;    // SELECT register contents.

  axil_pkg::addr_t slot_off;    // Address relative to the first slot register.
  idx_t            slot_idx;    // Core addressed by a slot register access.
  idx_t            release_idx; // Core named by a RELEASE write.
  logic            release_ok;  // That core exists.

  always_comb begin
    for (int i = 0; i < PORT_COUNT; i++) begin
      slot_flat[i*SLOT_WIDTH +: SLOT_WIDTH] = slots[i];
    end
  end

  // Zero counts drop out by themselves, so the mask alone serves as the valid vector.
  max_finder_tree #(
    .PORT_COUNT (PORT_COUNT),
    .SLOT_WIDTH (SLOT_WIDTH)
  ) u_finder (
    .values    (slot_flat),
    .valids    (enable),
    .max_val   (sel_val),
    .max_ptr   (sel_ptr),
    .max_valid (sel_valid)
  );

  always_comb begin
    sel_word = '0; // Unused bits read as zero.
    sel_word[bal_regs_pkg::SEL_VALID_BIT]                  = sel_valid;
    sel_word[bal_regs_pkg::SEL_COUNT_LSB +: SLOT_WIDTH]    = sel_val;
    sel_word[bal_regs_pkg::SEL_INDEX_LSB +: IDX_W]         = sel_ptr;
  end

  assign slot_off    = op.addr - bal_regs_pkg::REG_SLOTS_BASE;
  assign slot_idx    = slot_off[IDX_W+1:2]; // Slot registers are one word apart.
  assign release_idx = op.wdata[IDX_W-1:0];
  assign release_ok  = op.wdata < PORT_COUNT;

  // Refusals are judged on the state before this operation is applied.
  always_comb begin
    case (op.op)
      bal_regs_pkg::OP_ALLOC:   op.err = !sel_valid;  // Nowhere to send the job.
      bal_regs_pkg::OP_RELEASE: op.err = !release_ok;
      bal_regs_pkg::OP_BAD:     op.err = 1'b1;
      default:                  op.err = 1'b0;
    endcase
  end

  // Read data, zero for anything that is not a read.
  always_comb begin
    op.rdata = '0;
    if (op.op == bal_regs_pkg::OP_READ) begin
      if (op.addr == bal_regs_pkg::REG_ENABLE) begin
        op.rdata[PORT_COUNT-1:0] = enable;
      end else if (op.addr == bal_regs_pkg::REG_SELECT) begin
        op.rdata = sel_word;
      end else begin
        op.rdata[SLOT_WIDTH-1:0] = slots[slot_idx]; // The decoder vouches for the range.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      enable <= '1; // Every core starts out eligible.
      for (int i = 0; i < PORT_COUNT; i++) begin
        slots[i] <= '0;
      end
    end else if (op.op_valid && !op.err) begin
      case (op.op)
        bal_regs_pkg::OP_SET_ENABLE: enable <= op.wdata[PORT_COUNT-1:0];
        bal_regs_pkg::OP_SET_SLOTS:  slots[slot_idx] <= op.wdata[SLOT_WIDTH-1:0];
        bal_regs_pkg::OP_ALLOC:      slots[sel_ptr] <= sel_val - 1'b1; // Never below zero.
        bal_regs_pkg::OP_RELEASE: begin
          if (slots[release_idx] != '1) begin // Stay at the top count.
            slots[release_idx] <= slots[release_idx] + 1'b1;
          end
        end
        default: ; // Reads change nothing.
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== tests/core_balancer_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

// Protocol and state checks on the balancer ports, bound into every core_balancer.
module core_balancer_assertions (
  input logic            clk,
  input logic            reset,
  input logic            awready,
  input logic            wready,
  input logic            arready,
  input axil_pkg::resp_t bresp,
  input logic            bvalid,
  input logic            bready,
  input axil_pkg::data_t rdata,
  input axil_pkg::resp_t rresp,
  input logic            rvalid,
  input logic            rready
);

  int unsigned fail_count = 0; // Read by the testbench at the end of the run.

  // A response must not vanish or change before the master takes it.
  a_b_hold: assert property (@(posedge clk) disable iff (reset)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      fail_count++;
      $error("B response dropped or changed before bready.");
    end

  a_r_hold: assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata))
    else begin
      fail_count++;
      $error("R response dropped or changed before rready.");
    end

  // Only one transaction is ever in flight.
  a_one_resp: assert property (@(posedge clk) disable iff (reset) !(bvalid && rvalid))
    else begin
      fail_count++;
      $error("B and R responses are pending at the same time.");
    end

  a_aw_w_pair: assert property (@(posedge clk) disable iff (reset) awready == wready)
    else begin
      fail_count++;
      $error("awready and wready differ.");
    end

  // A held response blocks every address channel.
  a_busy_block: assert property (@(posedge clk) disable iff (reset)
    (bvalid || rvalid) |-> !(awready || wready || arready))
    else begin
      fail_count++;
      $error("A ready is high while a response is held.");
    end

endmodule

bind core_balancer core_balancer_assertions u_assert (.*);

`default_nettype wire

// ==== tests/tb_core_balancer.sv ====
`timescale 1ns/10ps
`default_nettype none

// Directed tests of the core balancer against a small software model of its registers.
module tb_core_balancer;

  localparam int  PORTS      = 8;
  localparam int  TEST_COUNT = 6;
  localparam time CLK_PERIOD = 20ns;

  logic clk;
  logic reset;
  axil_pkg::addr_t awaddr;
  axil_pkg::addr_t araddr;
  axil_pkg::data_t wdata;
  axil_pkg::data_t rdata;
  axil_pkg::resp_t bresp;
  axil_pkg::resp_t rresp;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;

  logic [7:0] slots_m [PORTS]; // Expected free slots per core.
  logic [7:0] mask_m;          // Expected enable mask.

  core_balancer #(.PORT_COUNT(PORTS), .SLOT_WIDTH(8)) dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // The whole run gets 200 clock periods per test.
  initial begin
    #(TEST_COUNT * 200 * CLK_PERIOD);
    $display("Timeout: the DUT stopped answering on the AXI4-Lite bus.");
    $display("TB FAILED");
    $fatal(1, "Watchdog expired.");
  end

  // Any failed bound assertion ends the run right away.
  initial begin
    wait (dut.u_assert.fail_count != 0);
    $display("A bound protocol assertion failed at %0t.", $time);
    $display("TB FAILED");
    $fatal(1, "Protocol check failed.");
  end

  task automatic compare_word(input string name, input axil_pkg::data_t got,
                              input axil_pkg::data_t exp);
    assert (got === exp) else begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("TB FAILED");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  function automatic axil_pkg::addr_t slot_addr(input int i);
    return axil_pkg::addr_t'(int'(bal_regs_pkg::REG_SLOTS_BASE) + 4 * i);
  endfunction

  // True for an aligned slot register of an existing core.
  function automatic logic is_slot(input axil_pkg::addr_t a);
    return a[1:0] == 2'b00 && a >= bal_regs_pkg::REG_SLOTS_BASE && a < slot_addr(PORTS);
  endfunction

  // Enabled core with the most free slots, lowest index on a tie, zero when none has any.
  function automatic axil_pkg::data_t expected_select();
    axil_pkg::data_t word;
    int best;
    word = '0;
    best = 0;
    for (int i = 0; i < PORTS; i++) begin
      if (mask_m[i] && slots_m[i] > best) begin
        best = slots_m[i];
        word = '0;
        word[bal_regs_pkg::SEL_VALID_BIT] = 1'b1;
        word[bal_regs_pkg::SEL_COUNT_LSB +: 8] = slots_m[i];
        word[bal_regs_pkg::SEL_INDEX_LSB +: 8] = 8'(i);
      end
    end
    return word;
  endfunction

  // Write with bready held low for hold cycles after bvalid rises.
  task automatic axil_write(input axil_pkg::addr_t a, input axil_pkg::data_t d,
                            input int hold, output axil_pkg::resp_t resp);
    @(negedge clk);
    awaddr  = a;
    wdata   = d;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do @(posedge clk); while (!(awready && wready));
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = (hold == 0);
    do @(posedge clk); while (!bvalid);
    resp = bresp;
    for (int i = 0; i < hold; i++) begin
      @(posedge clk);
      compare_word("bvalid", bvalid, 1'b1);
      compare_word("bresp", bresp, resp); // Must not move while held.
      compare_word("awready", awready, 1'b0);
      compare_word("arready", arready, 1'b0);
    end
    if (hold > 0) begin
      @(negedge clk);
      bready = 1'b1;
      @(posedge clk);
    end
    @(negedge clk);
    bready = 1'b0;
  endtask

  // Read with rready held low for hold cycles after rvalid rises.
  task automatic axil_read(input axil_pkg::addr_t a, input int hold,
                           output axil_pkg::data_t d, output axil_pkg::resp_t resp);
    @(negedge clk);
    araddr  = a;
    arvalid = 1'b1;
    do @(posedge clk); while (!arready);
    @(negedge clk);
    arvalid = 1'b0;
    rready  = (hold == 0);
    do @(posedge clk); while (!rvalid);
    d    = rdata;
    resp = rresp;
    for (int i = 0; i < hold; i++) begin
      @(posedge clk);
      compare_word("rvalid", rvalid, 1'b1);
      compare_word("rdata", rdata, d);
      compare_word("rresp", rresp, resp);
      compare_word("awready", awready, 1'b0);
      compare_word("arready", arready, 1'b0);
    end
    if (hold > 0) begin
      @(negedge clk);
      rready = 1'b1;
      @(posedge clk);
    end
    @(negedge clk);
    rready = 1'b0;
  endtask

  // Applies the register rules to the model, then checks the DUT's write response.
  task automatic write_checked(input axil_pkg::addr_t a, input axil_pkg::data_t d,
                               input int hold);
    axil_pkg::data_t sel;
    axil_pkg::resp_t exp;
    axil_pkg::resp_t got;
    exp = axil_pkg::RESP_OKAY;
    sel = expected_select();
    if (a == bal_regs_pkg::REG_ENABLE) begin
      mask_m = d[7:0];
    end else if (a == bal_regs_pkg::REG_ALLOC) begin
      if (sel[bal_regs_pkg::SEL_VALID_BIT]) begin
        slots_m[sel[7:0]] = slots_m[sel[7:0]] - 8'd1; // One job goes to the selection.
      end else begin
        exp = axil_pkg::RESP_SLVERR;
      end
    end else if (a == bal_regs_pkg::REG_RELEASE) begin
      if (d < PORTS) begin
        if (slots_m[d] != 8'hff) slots_m[d] = slots_m[d] + 8'd1;
      end else begin
        exp = axil_pkg::RESP_SLVERR;
      end
    end else if (is_slot(a)) begin
      slots_m[(a - bal_regs_pkg::REG_SLOTS_BASE) / 4] = d[7:0];
    end else begin
      exp = axil_pkg::RESP_SLVERR; // SELECT and unmapped addresses.
    end
    axil_write(a, d, hold, got);
    compare_word("bresp", got, exp);
  endtask

  task automatic read_checked(input axil_pkg::addr_t a, input int hold);
    axil_pkg::data_t exp_d;
    axil_pkg::resp_t exp_r;
    axil_pkg::data_t got_d;
    axil_pkg::resp_t got_r;
    exp_d = '0;
    exp_r = axil_pkg::RESP_OKAY;
    if (a == bal_regs_pkg::REG_ENABLE) exp_d = mask_m;
    else if (a == bal_regs_pkg::REG_SELECT) exp_d = expected_select();
    else if (is_slot(a)) exp_d = slots_m[(a - bal_regs_pkg::REG_SLOTS_BASE) / 4];
    else exp_r = axil_pkg::RESP_SLVERR;
    axil_read(a, hold, got_d, got_r);
    compare_word("rresp", got_r, exp_r);
    compare_word("rdata", got_d, exp_d);
  endtask

  task automatic read_reset_values();
    read_checked(bal_regs_pkg::REG_ENABLE, 0);
    read_checked(bal_regs_pkg::REG_SELECT, 0);
    for (int i = 0; i < PORTS; i++) read_checked(slot_addr(i), 0);
  endtask

  task automatic pick_largest_count();
    logic [7:0] counts [PORTS] = '{8'd3, 8'd9, 8'd4, 8'd12, 8'd7, 8'd1, 8'd5, 8'd2};
    for (int i = 0; i < PORTS; i++) write_checked(slot_addr(i), counts[i], 0);
    read_checked(bal_regs_pkg::REG_SELECT, 0);
    write_checked(slot_addr(6), 8'd12, 0); // Ties with core 3, which stays selected.
    read_checked(bal_regs_pkg::REG_SELECT, 0);
    write_checked(slot_addr(1), 8'd12, 0);
    read_checked(bal_regs_pkg::REG_SELECT, 0);
  endtask

  task automatic mask_out_cores();
    write_checked(bal_regs_pkg::REG_ENABLE, 32'h0000_00f5, 0); // Cores 1 and 3 drop out.
    read_checked(bal_regs_pkg::REG_ENABLE, 0);
    read_checked(bal_regs_pkg::REG_SELECT, 0);
    write_checked(bal_regs_pkg::REG_ENABLE, 32'h0, 0);
    read_checked(bal_regs_pkg::REG_SELECT, 0);
    write_checked(bal_regs_pkg::REG_ENABLE, 32'h0000_00ff, 0);
  endtask

  task automatic drain_by_alloc();
    for (int n = 0; n < 10; n++) begin
      write_checked(bal_regs_pkg::REG_ALLOC, 32'h0, 0);
      read_checked(bal_regs_pkg::REG_SELECT, 0);
    end
    write_checked(bal_regs_pkg::REG_ENABLE, 32'h0, 0);
    write_checked(bal_regs_pkg::REG_ALLOC, 32'h0, 0); // Nothing to pick from.
    for (int i = 0; i < PORTS; i++) read_checked(slot_addr(i), 0);
    write_checked(bal_regs_pkg::REG_ENABLE, 32'h0000_00ff, 0);
  endtask

  task automatic release_and_refuse();
    write_checked(bal_regs_pkg::REG_RELEASE, 32'd5, 0);
    read_checked(slot_addr(5), 0);
    write_checked(slot_addr(2), 8'hfe, 0);
    write_checked(bal_regs_pkg::REG_RELEASE, 32'd2, 0);
    write_checked(bal_regs_pkg::REG_RELEASE, 32'd2, 0); // Already at the top count.
    read_checked(slot_addr(2), 0);
    write_checked(bal_regs_pkg::REG_RELEASE, 32'd8, 0);
    write_checked(bal_regs_pkg::REG_SELECT, 32'h1234, 0);
    write_checked(8'h10, 32'h1, 0);
    read_checked(bal_regs_pkg::REG_ALLOC, 0);
    read_checked(8'h40, 0);
    read_checked(8'h22, 0);
    read_checked(bal_regs_pkg::REG_SELECT, 0);
  endtask

  // A second transaction waits while the first response is held back.
  task automatic hold_responses();
    fork
      write_checked(slot_addr(0), 8'h33, 6);
      begin
        repeat (3) @(negedge clk);
        read_checked(slot_addr(0), 0);
      end
    join
    fork
      read_checked(bal_regs_pkg::REG_SELECT, 6);
      begin
        repeat (3) @(negedge clk);
        write_checked(slot_addr(1), 8'h44, 0);
      end
    join
    read_checked(slot_addr(1), 0);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    mask_m = 8'hff;
    for (int i = 0; i < PORTS; i++) slots_m[i] = 8'd0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    read_reset_values();
    pick_largest_count();
    mask_out_cores();
    drain_by_alloc();
    release_and_refuse();
    hold_responses();
    repeat (2) @(negedge clk);
    if (dut.u_assert.fail_count == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("Bound protocol checks failed %0d times.", dut.u_assert.fail_count);
      $display("TB FAILED");
      $fatal(1, "Protocol checks failed.");
    end
  end

endmodule

`default_nettype wire
